/* verilog/fpu_pkg.sv */
// Single precision only; denormal encodings are never produced by the datapath
package fpu_pkg;

	//////////////////////////////
	// Format constants
	//////////////////////////////
	localparam int FLOAT_W  = 32;   // Operand and result width
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;   // Stored fraction, hidden bit excluded
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;  // Inf and NaN exponent

	// Every invalid operation returns this quiet NaN
	localparam logic [FLOAT_W-1:0] QNAN_CANON = 32'h7fc0_0001;

	//////////////////////////////
	// Encodings
	//////////////////////////////
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2
	} fpu_op_e;

	typedef enum logic [1:0] {
		RM_NEAREST = 2'd0,  // Ties to even
		RM_ZERO    = 2'd1,
		RM_UP      = 2'd2,  // Toward +inf
		RM_DOWN    = 2'd3   // Toward -inf
	} round_mode_e;

endpackage

/* verilog/operand_classify.sv */
// Denormal operands flushed to signed zero on entry; special-case result lags three cycles
module operand_classify (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [fpu_pkg::FLOAT_W-1:0] opa,
	input  logic [fpu_pkg::FLOAT_W-1:0] opb,
	input  fpu_pkg::fpu_op_e            fpu_op,
	input  fpu_pkg::round_mode_e        rmode,
	output logic [fpu_pkg::FLOAT_W-1:0] opa_r,
	output logic [fpu_pkg::FLOAT_W-1:0] opb_r,
	output fpu_pkg::fpu_op_e            op_r,
	output fpu_pkg::round_mode_e        rmode_r,
	output logic                        spec_hit,
	output logic                        spec_nan,
	output logic                        spec_inf,
	output logic                        spec_zero,
	output logic                        spec_sign,
	output logic                        spec_snan
);
	import fpu_pkg::*;

	logic       a_nan, a_snan, a_inf, a_zero;
	logic       b_nan, b_snan, b_inf, b_zero;
	logic       is_mul, sb_eff;
	logic       nan_d, inf_d, zero_d, sign_d;
	logic [5:0] spec_q1, spec_q2, spec_q3;  // {hit, nan, inf, zero, sign, snan}

	// Input registers
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			opa_r   <= '0;
			opb_r   <= '0;
			op_r    <= OP_ADD;
			rmode_r <= RM_NEAREST;
		end
		else
		begin
			opa_r   <= (opa[30:23] == '0) ? {opa[31], 31'b0} : opa;  // Flush denormals
			opb_r   <= (opb[30:23] == '0) ? {opb[31], 31'b0} : opb;
			op_r    <= fpu_op;
			rmode_r <= rmode;
		end
	end

	// Operand classes
	assign a_inf  = (&opa_r[30:23]) & (opa_r[22:0] == '0);
	assign a_nan  = (&opa_r[30:23]) & (opa_r[22:0] != '0);
	assign a_snan = a_nan & ~opa_r[22];  // Quiet bit clear
	assign a_zero = (opa_r[30:23] == '0);
	assign b_inf  = (&opb_r[30:23]) & (opb_r[22:0] == '0);
	assign b_nan  = (&opb_r[30:23]) & (opb_r[22:0] != '0);
	assign b_snan = b_nan & ~opb_r[22];
	assign b_zero = (opb_r[30:23] == '0);

	assign is_mul = (op_r == OP_MUL);
	assign sb_eff = opb_r[31] ^ (op_r == OP_SUB);  // Sign of b as actually added

	// Invalid operations
	assign nan_d = a_nan | b_nan
		| (~is_mul & a_inf & b_inf & (opa_r[31] != sb_eff))  // inf - inf
		| (is_mul & ((a_inf & b_zero) | (b_inf & a_zero)));   // 0 * inf
	assign inf_d  = ~nan_d & (a_inf | b_inf);
	assign zero_d = ~nan_d & ~inf_d & is_mul & (a_zero | b_zero);

	// NaN sign fixed at 0
	assign sign_d = nan_d  ? 1'b0 :
	                is_mul ? opa_r[31] ^ opb_r[31] :
	                a_inf  ? opa_r[31] : sb_eff;

	// Hold decision until post_norm catches up
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			spec_q1 <= '0;
			spec_q2 <= '0;
			spec_q3 <= '0;
		end
		else
		begin
			spec_q1 <= {nan_d | inf_d | zero_d, nan_d, inf_d, zero_d, sign_d, a_snan | b_snan};
			spec_q2 <= spec_q1;
			spec_q3 <= spec_q2;
		end
	end

	assign {spec_hit, spec_nan, spec_inf, spec_zero, spec_sign, spec_snan} = spec_q3;

endmodule

/* verilog/addsub_prenorm.sv */
// Operands must already be flushed; an exact zero sum sign is decided here
module addsub_prenorm (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [fpu_pkg::FLOAT_W-1:0] opa_r,
	input  logic [fpu_pkg::FLOAT_W-1:0] opb_r,
	input  fpu_pkg::fpu_op_e            op_r,
	input  fpu_pkg::round_mode_e        rmode_r,
	output logic [26:0]                 fracta,
	output logic [26:0]                 fractb,
	output logic [fpu_pkg::EXP_W-1:0]   exp_big,
	output logic                        sub_eff,
	output logic                        sign_as,
	output logic                        zero_sign,
	output fpu_pkg::round_mode_e        rmode_p,
	output fpu_pkg::fpu_op_e            op_p
);
	import fpu_pkg::*;

	logic             sa, sb_eff, a_big, eff_sub;
	logic [EXP_W-1:0] ea, eb, exp_diff;
	logic [23:0]      ma, mb, m_big, m_small;
	logic [49:0]      shifted;   // Small mantissa with room for lost bits
	logic [26:0]      small_al;

	assign sa      = opa_r[31];
	assign sb_eff  = opb_r[31] ^ (op_r == OP_SUB);
	assign eff_sub = sa ^ sb_eff;
	assign ea      = opa_r[30:23];
	assign eb      = opb_r[30:23];
	assign ma      = {ea != '0, opa_r[22:0]};  // Hidden bit
	assign mb      = {eb != '0, opb_r[22:0]};

	// Magnitude compare over exponent and fraction together
	assign a_big    = (opa_r[30:0] >= opb_r[30:0]);
	assign m_big    = a_big ? ma : mb;
	assign m_small  = a_big ? mb : ma;
	assign exp_diff = a_big ? ea - eb : eb - ea;

	//////////////////////////////
	// Alignment shift
	//////////////////////////////
	assign shifted = {m_small, 26'b0} >> exp_diff;

	// Beyond 26 places only the sticky bit survives
	assign small_al = (exp_diff > 8'd26) ? {26'b0, |m_small}
	                                     : {shifted[49:24], |shifted[23:0]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fracta    <= '0;
			fractb    <= '0;
			exp_big   <= '0;
			sub_eff   <= 1'b0;
			sign_as   <= 1'b0;
			zero_sign <= 1'b0;
			rmode_p   <= RM_NEAREST;
			op_p      <= OP_ADD;
		end
		else
		begin
			fracta    <= {m_big, 3'b000};  // Empty guard, round, sticky
			fractb    <= small_al;
			exp_big   <= a_big ? ea : eb;
			sub_eff   <= eff_sub;
			sign_as   <= a_big ? sa : sb_eff;
			zero_sign <= eff_sub ? (rmode_r == RM_DOWN) : sa;  // x-x is -0 only rounding down
			rmode_p   <= rmode_r;
			op_p      <= op_r;
		end
	end

endmodule

/* verilog/mul_prenorm.sv */
// Zero, inf and NaN operands give garbage here; the special-case path overrides them
module mul_prenorm (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [fpu_pkg::FLOAT_W-1:0] opa_r,
	input  logic [fpu_pkg::FLOAT_W-1:0] opb_r,
	output logic [23:0]                 manta,
	output logic [23:0]                 mantb,
	output logic signed [9:0]           exp_sum,
	output logic                        sign_mul
);
	import fpu_pkg::*;

	logic signed [9:0] ea_w, eb_w;  // Wide enough for 381 and for -125

	assign ea_w = $signed({2'b00, opa_r[30:23]});
	assign eb_w = $signed({2'b00, opb_r[30:23]});

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			manta    <= '0;
			mantb    <= '0;
			exp_sum  <= '0;
			sign_mul <= 1'b0;
		end
		else
		begin
			manta    <= {opa_r[30:23] != '0, opa_r[22:0]};
			mantb    <= {opb_r[30:23] != '0, opb_r[22:0]};
			exp_sum  <= ea_w + eb_w - 10'(EXP_BIAS);  // One bias removed
			sign_mul <= opa_r[31] ^ opb_r[31];
		end
	end

endmodule

/* verilog/mantissa_arith.sv */
// Both results land with the integer bits at [47:46] so post_norm needs one layout
module mantissa_arith (
	input  logic                      clk,
	input  logic                      arst_n,
	input  fpu_pkg::fpu_op_e          op_p,
	input  fpu_pkg::round_mode_e      rmode_p,
	input  logic [26:0]               fracta,
	input  logic [26:0]               fractb,
	input  logic                      sub_eff,
	input  logic [fpu_pkg::EXP_W-1:0] exp_big,
	input  logic                      sign_as,
	input  logic                      zero_sign,
	input  logic [23:0]               manta,
	input  logic [23:0]               mantb,
	input  logic signed [9:0]         exp_sum,
	input  logic                      sign_mul,
	output logic [47:0]               fract_raw,
	output logic signed [9:0]         exp_raw,
	output logic                      sign_raw,
	output logic                      zero_sign_a,
	output fpu_pkg::fpu_op_e          op_a,
	output fpu_pkg::round_mode_e      rmode_a
);
	import fpu_pkg::*;

	logic [27:0] sum;  // Carry plus 27 aligned bits

	// fracta never below fractb so the difference stays positive
	assign sum = sub_eff ? {1'b0, fracta} - {1'b0, fractb}
	                     : {1'b0, fracta} + {1'b0, fractb};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fract_raw   <= '0;
			exp_raw     <= '0;
			sign_raw    <= 1'b0;
			zero_sign_a <= 1'b0;
			op_a        <= OP_ADD;
			rmode_a     <= RM_NEAREST;
		end
		else
		begin
			if (op_p == OP_MUL)
			begin
				fract_raw <= manta * mantb;  // 1.x times 1.x
				exp_raw   <= exp_sum;
				sign_raw  <= sign_mul;
			end
			else
			begin
				fract_raw <= {sum, 20'b0};
				exp_raw   <= $signed({2'b00, exp_big});
				sign_raw  <= sign_as;
			end
			zero_sign_a <= zero_sign;
			op_a        <= op_p;
			rmode_a     <= rmode_p;
		end
	end

endmodule

/* verilog/post_norm.sv */
// Results below the smallest normal flush to signed zero; no denormal output
module post_norm (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [47:0]                 fract_raw,
	input  logic signed [9:0]           exp_raw,
	input  logic                        sign_raw,
	input  logic                        zero_sign_a,
	input  fpu_pkg::fpu_op_e            op_a,
	input  fpu_pkg::round_mode_e        rmode_a,
	output logic [fpu_pkg::FLOAT_W-1:0] norm_out,
	output logic                        norm_ine,
	output logic                        norm_ovf,
	output logic                        norm_unf,
	output logic                        norm_zero
);
	import fpu_pkg::*;

	logic [5:0]         lz;
	logic [47:0]        norm;
	logic               guard, sticky, round_up, carry, to_inf, zsign;
	logic [24:0]        mant_rnd;
	logic signed [10:0] exp_n, exp_f;

	//////////////////////////////
	// Normalize
	//////////////////////////////
	always_comb
	begin
		lz = 6'd48;
		for (int i = 0; i < 48; i++)
		begin
			if (fract_raw[i])
				lz = 6'(47 - i);  // Highest set bit wins
		end
	end

	assign norm   = fract_raw << lz;
	assign guard  = norm[23];
	assign sticky = |norm[22:0];  // Round and sticky folded together

	// Leading one at bit 47 is worth 2^1
	assign exp_n = exp_raw + 11'sd1 - $signed({5'b0, lz});

	//////////////////////////////
	// Round
	//////////////////////////////
	always_comb
	begin
		case (rmode_a)
			RM_NEAREST: round_up = guard & (sticky | norm[24]);  // Ties to even
			RM_UP:      round_up = ~sign_raw & (guard | sticky);
			RM_DOWN:    round_up = sign_raw & (guard | sticky);
			default:    round_up = 1'b0;
		endcase
	end

	assign mant_rnd = {1'b0, norm[47:24]} + 25'(round_up);
	assign carry    = mant_rnd[24];  // 1.11..1 rolled over to 10.0
	assign exp_f    = exp_n + $signed({10'b0, carry});

	// Overflow goes to inf unless rounding toward zero on that side
	assign to_inf = (rmode_a == RM_NEAREST)
		| ((rmode_a == RM_UP) & ~sign_raw)
		| ((rmode_a == RM_DOWN) & sign_raw);

	assign zsign = (op_a == OP_MUL) ? sign_raw : zero_sign_a;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			norm_out  <= '0;
			norm_ine  <= 1'b0;
			norm_ovf  <= 1'b0;
			norm_unf  <= 1'b0;
			norm_zero <= 1'b0;
		end
		else
		begin
			norm_ovf  <= 1'b0;
			norm_unf  <= 1'b0;
			norm_zero <= 1'b0;
			norm_ine  <= guard | sticky;
			if (fract_raw == '0)
			begin
				norm_out  <= {zsign, 31'b0};  // Exact zero
				norm_zero <= 1'b1;
			end
			else if (exp_f < 11'sd1)
			begin
				norm_out  <= {sign_raw, 31'b0};  // Flush
				norm_unf  <= 1'b1;
				norm_ine  <= 1'b1;
				norm_zero <= 1'b1;
			end
			else if (exp_f >= EXP_MAX)
			begin
				norm_out <= to_inf ? {sign_raw, 8'hff, 23'b0} : {sign_raw, 8'hfe, {23{1'b1}}};
				norm_ovf <= 1'b1;
				norm_ine <= 1'b1;
			end
			else
				norm_out <= {sign_raw, exp_f[7:0], mant_rnd[22:0]};  // Fraction zero on carry
		end
	end

endmodule

/* verilog/result_select.sv */
// NaN results always come out as the canonical quiet NaN with positive sign
module result_select (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [fpu_pkg::FLOAT_W-1:0] norm_out,
	input  logic                        norm_ine,
	input  logic                        norm_ovf,
	input  logic                        norm_unf,
	input  logic                        norm_zero,
	input  logic                        spec_hit,
	input  logic                        spec_nan,
	input  logic                        spec_inf,
	input  logic                        spec_zero,
	input  logic                        spec_sign,
	input  logic                        spec_snan,
	output logic [fpu_pkg::FLOAT_W-1:0] out,
	output logic                        inf,
	output logic                        snan,
	output logic                        qnan,
	output logic                        ine,
	output logic                        overflow,
	output logic                        underflow,
	output logic                        zero
);
	import fpu_pkg::*;

	logic [FLOAT_W-1:0] spec_out;

	assign spec_out = spec_nan ? QNAN_CANON :
	                  spec_inf ? {spec_sign, {EXP_W{1'b1}}, 23'b0} :
	                             {spec_sign, 31'b0};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out       <= '0;
			inf       <= 1'b0;
			snan      <= 1'b0;
			qnan      <= 1'b0;
			ine       <= 1'b0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
			zero      <= 1'b0;
		end
		else if (spec_hit)
		begin
			out       <= spec_out;
			inf       <= spec_inf;
			snan      <= spec_snan;  // Only set alongside spec_nan
			qnan      <= spec_nan;
			ine       <= 1'b0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
			zero      <= spec_zero;
		end
		else
		begin
			out       <= norm_out;
			inf       <= norm_ovf & (&norm_out[30:23]);  // Not when clamped to max finite
			snan      <= 1'b0;
			qnan      <= 1'b0;
			ine       <= norm_ine;
			overflow  <= norm_ovf;
			underflow <= norm_unf;
			zero      <= norm_zero;
		end
	end

endmodule

/* verilog/fpu_top.sv */
// Fixed latency of four cycles after the sampling edge; one operation per cycle
module fpu_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [fpu_pkg::FLOAT_W-1:0] opa,
	input  logic [fpu_pkg::FLOAT_W-1:0] opb,
	input  fpu_pkg::fpu_op_e            fpu_op,
	input  fpu_pkg::round_mode_e        rmode,
	output logic [fpu_pkg::FLOAT_W-1:0] out,
	output logic                        inf,
	output logic                        snan,
	output logic                        qnan,
	output logic                        ine,
	output logic                        overflow,
	output logic                        underflow,
	output logic                        zero
);
	import fpu_pkg::*;

	// Stage 0
	logic [FLOAT_W-1:0] opa_r, opb_r;
	fpu_op_e            op_r;
	round_mode_e        rmode_r;
	logic               spec_hit, spec_nan, spec_inf, spec_zero, spec_sign, spec_snan;
	// Stage 1
	logic [26:0]        fracta, fractb;
	logic [EXP_W-1:0]   exp_big;
	logic               sub_eff, sign_as, zero_sign, sign_mul;
	round_mode_e        rmode_p;
	fpu_op_e            op_p;
	logic [23:0]        manta, mantb;
	logic signed [9:0]  exp_sum;
	// Stage 2
	logic [47:0]        fract_raw;
	logic signed [9:0]  exp_raw;
	logic               sign_raw, zero_sign_a;
	fpu_op_e            op_a;
	round_mode_e        rmode_a;
	// Stage 3
	logic [FLOAT_W-1:0] norm_out;
	logic               norm_ine, norm_ovf, norm_unf, norm_zero;

	operand_classify u_classify (
		.clk, .arst_n, .opa, .opb, .fpu_op, .rmode,
		.opa_r, .opb_r, .op_r, .rmode_r,
		.spec_hit, .spec_nan, .spec_inf, .spec_zero, .spec_sign, .spec_snan
	);

	addsub_prenorm u_addsub_pre (
		.clk, .arst_n, .opa_r, .opb_r, .op_r, .rmode_r,
		.fracta, .fractb, .exp_big, .sub_eff, .sign_as, .zero_sign, .rmode_p, .op_p
	);

	mul_prenorm u_mul_pre (
		.clk, .arst_n, .opa_r, .opb_r,
		.manta, .mantb, .exp_sum, .sign_mul
	);

	mantissa_arith u_arith (
		.clk, .arst_n, .op_p, .rmode_p,
		.fracta, .fractb, .sub_eff, .exp_big, .sign_as, .zero_sign,
		.manta, .mantb, .exp_sum, .sign_mul,
		.fract_raw, .exp_raw, .sign_raw, .zero_sign_a, .op_a, .rmode_a
	);

	post_norm u_post_norm (
		.clk, .arst_n, .fract_raw, .exp_raw, .sign_raw, .zero_sign_a, .op_a, .rmode_a,
		.norm_out, .norm_ine, .norm_ovf, .norm_unf, .norm_zero
	);

	result_select u_result (
		.clk, .arst_n,
		.norm_out, .norm_ine, .norm_ovf, .norm_unf, .norm_zero,
		.spec_hit, .spec_nan, .spec_inf, .spec_zero, .spec_sign, .spec_snan,
		.out, .inf, .snan, .qnan, .ine, .overflow, .underflow, .zero
	);

endmodule

/* dv/fpu_tb.sv */
// Integer operands stay below 2^11 in magnitude so results are exact; denormals as flush cases
module fpu_tb;
	import fpu_pkg::*;

	localparam int N_RAND  = 60;
	localparam int N_ZDIFF = 8;   // Two operations, four modes
	localparam int N_ROUND = 16;  // Two sizes of tail, two signs, four modes
	localparam int N_OVF   = 8;
	localparam int N_UNF   = 2;
	localparam int N_SPEC  = 18;
	localparam int N_OPS   = N_RAND + N_ZDIFF + N_ROUND + N_OVF + N_UNF + N_SPEC;

	// Flag vector is {inf, snan, qnan, ine, overflow, underflow, zero}
	localparam logic [6:0] FL_INF  = 7'h40;
	localparam logic [6:0] FL_SNAN = 7'h20;
	localparam logic [6:0] FL_QNAN = 7'h10;
	localparam logic [6:0] FL_INE  = 7'h08;
	localparam logic [6:0] FL_OVF  = 7'h04;
	localparam logic [6:0] FL_UNF  = 7'h02;
	localparam logic [6:0] FL_ZERO = 7'h01;

	logic               clk;
	logic               arst_n;
	logic [FLOAT_W-1:0] opa, opb;
	fpu_op_e            fpu_op;
	round_mode_e        rmode;
	logic [FLOAT_W-1:0] out;
	logic               inf, snan, qnan, ine, overflow, underflow, zero;
	logic [6:0]         flags;

	logic               in_valid;      // An op is on the inputs this cycle
	logic [4:0]         vld_pipe;      // Follows each op down to the outputs
	logic               reset_window;  // Outputs must read zero
	logic [FLOAT_W-1:0] exp_out;       // Expected value for the current output
	logic [6:0]         exp_flag;
	logic [FLOAT_W-1:0] exp_out_q[$];
	logic [6:0]         exp_flag_q[$];
	int                 seed;

	fpu_top dut (
		.clk, .arst_n, .opa, .opb, .fpu_op, .rmode,
		.out, .inf, .snan, .qnan, .ine, .overflow, .underflow, .zero
	);

	assign flags = {inf, snan, qnan, ine, overflow, underflow, zero};

	always #10 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// Exact conversion, valid while the magnitude fits in 24 bits
	function automatic logic [31:0] int_to_float(input int v);
		logic        s;
		int unsigned mag;
		int          msb;
		int          i;
		s   = (v < 0);
		mag = s ? -v : v;
		if (mag == 0)
			return 32'h0;  // Integer zero is +0
		msb = 0;
		for (i = 0; i < 32; i++)
			if (mag[i])
				msb = i;
		return {s, 8'(127 + msb), 23'(mag << (23 - msb))};  // Hidden bit drops off the top
	endfunction

	// Directed and nearest rounding for an inexact magnitude, never a tie
	function automatic logic rounds_away(input logic s, input round_mode_e rm,
		input logic over_half);
		case (rm)
			RM_NEAREST: return over_half;
			RM_UP:      return !s;  // Toward +inf grows positive values only
			RM_DOWN:    return s;
			default:    return 1'b0;
		endcase
	endfunction

	task automatic issue(input logic [31:0] a, input logic [31:0] b, input fpu_op_e op,
		input round_mode_e rm, input logic [31:0] e_out, input logic [6:0] e_flag);
		@(posedge clk);
		opa      <= a;
		opb      <= b;
		fpu_op   <= op;
		rmode    <= rm;
		in_valid <= 1'b1;
		exp_out_q.push_back(e_out);
		exp_flag_q.push_back(e_flag);
	endtask

	//////////////////////////////
	// Test groups
	//////////////////////////////
	task automatic random_int_ops();
		int          a, b, r, sel, n;
		logic        sb_eff, zsign;
		fpu_op_e     op;
		round_mode_e rm;
		for (n = 0; n < N_RAND; n++)
		begin
			a   = $random(seed) % 2048;
			b   = $random(seed) % 2048;
			sel = $unsigned($random(seed)) % 3;
			rm  = round_mode_e'(2'($random(seed)));
			op  = (sel == 0) ? OP_ADD : (sel == 1) ? OP_SUB : OP_MUL;
			r   = (sel == 0) ? a + b : (sel == 1) ? a - b : a * b;
			sb_eff = (b < 0) ^ (op == OP_SUB);
			if (op == OP_MUL)
				zsign = (a < 0) ^ (b < 0);
			else if ((a < 0) == sb_eff)
				zsign = (a < 0);  // Like signs keep their sign
			else
				zsign = (rm == RM_DOWN);  // x - x
			if (r == 0)
				issue(int_to_float(a), int_to_float(b), op, rm, {zsign, 31'b0}, FL_ZERO);
			else
				issue(int_to_float(a), int_to_float(b), op, rm, int_to_float(r), 7'h0);
		end
	endtask

	// Exact cancellation, which random pairs almost never produce
	task automatic cancel_ops();
		int          a, k;
		round_mode_e rm;
		logic [31:0] e;
		for (k = 0; k < N_ZDIFF; k++)
		begin
			a  = 1 + $unsigned($random(seed)) % 2047;  // Nonzero keeps it an effective subtract
			rm = round_mode_e'(k[1:0]);
			e  = {rm == RM_DOWN, 31'b0};  // -0 only rounding down
			if (k[2])
				issue(int_to_float(-a), int_to_float(a), OP_ADD, rm, e, FL_ZERO);
			else
				issue(int_to_float(a), int_to_float(a), OP_SUB, rm, e, FL_ZERO);
		end
	endtask

	// 1.0 plus 0.75 or 0.25 ulp, either sign
	task automatic rounding_ops();
		int          k;
		logic        s, over_half;
		round_mode_e rm;
		logic [31:0] tail, e;
		for (k = 0; k < N_ROUND; k++)
		begin
			s         = k[0];
			rm        = round_mode_e'(k[2:1]);
			over_half = k[3];
			tail      = over_half ? 32'h33c0_0000 : 32'h3300_0000;  // 3*2^-25 or 2^-25
			e = {s, 31'h3f80_0000 + 31'(rounds_away(s, rm, over_half))};
			issue({s, 31'h3f80_0000}, {s, tail[30:0]}, OP_ADD, rm, e, FL_INE);
		end
	endtask

	task automatic overflow_ops();
		int          k;
		logic        s, to_inf;
		round_mode_e rm;
		logic [31:0] e;
		for (k = 0; k < N_OVF; k++)
		begin
			s      = k[0];
			rm     = round_mode_e'(k[2:1]);
			to_inf = rounds_away(s, rm, 1'b1);  // Else clamp to largest finite
			e      = to_inf ? {s, 31'h7f80_0000} : {s, 31'h7f7f_ffff};
			issue({s, 31'h7f7f_ffff}, 32'h4000_0000, OP_MUL, rm, e,
				FL_OVF | FL_INE | (to_inf ? FL_INF : 7'h0));
		end
	endtask

	task automatic underflow_ops();
		// 2^-100 squared lands far below the smallest normal
		issue(32'h0d80_0000, 32'h0d80_0000, OP_MUL, RM_NEAREST, 32'h0000_0000,
			FL_UNF | FL_INE | FL_ZERO);
		issue(32'h8d80_0000, 32'h0d80_0000, OP_MUL, RM_UP, 32'h8000_0000,
			FL_UNF | FL_INE | FL_ZERO);
	endtask

	task automatic special_ops();
		issue(32'h7fc0_0000, 32'h3f80_0000, OP_ADD, RM_NEAREST, QNAN_CANON, FL_QNAN);
		issue(32'h4000_0000, 32'hffc1_2345, OP_MUL, RM_ZERO, QNAN_CANON, FL_QNAN);
		issue(32'h7f80_0001, 32'h4000_0000, OP_MUL, RM_NEAREST, QNAN_CANON, FL_SNAN | FL_QNAN);
		issue(32'h3f80_0000, 32'hffa0_0000, OP_SUB, RM_UP, QNAN_CANON, FL_SNAN | FL_QNAN);
		issue(32'h7f80_0000, 32'h7f80_0000, OP_SUB, RM_NEAREST, QNAN_CANON, FL_QNAN);
		issue(32'hff80_0000, 32'h7f80_0000, OP_ADD, RM_DOWN, QNAN_CANON, FL_QNAN);
		issue(32'h0000_0000, 32'h7f80_0000, OP_MUL, RM_NEAREST, QNAN_CANON, FL_QNAN);
		issue(32'hff80_0000, 32'h8000_0000, OP_MUL, RM_ZERO, QNAN_CANON, FL_QNAN);
		issue(32'h7f80_0000, 32'h40a0_0000, OP_ADD, RM_NEAREST, 32'h7f80_0000, FL_INF);
		issue(32'hff80_0000, 32'h40a0_0000, OP_ADD, RM_UP, 32'hff80_0000, FL_INF);
		issue(32'h40a0_0000, 32'h7f80_0000, OP_SUB, RM_NEAREST, 32'hff80_0000, FL_INF);
		issue(32'h7f80_0000, 32'h7f80_0000, OP_ADD, RM_DOWN, 32'h7f80_0000, FL_INF);
		issue(32'h7f80_0000, 32'hc000_0000, OP_MUL, RM_NEAREST, 32'hff80_0000, FL_INF);
		issue(32'hc040_0000, 32'h0000_0000, OP_MUL, RM_NEAREST, 32'h8000_0000, FL_ZERO);
		issue(32'h0000_0000, 32'h8000_0000, OP_MUL, RM_UP, 32'h8000_0000, FL_ZERO);
		// Denormals read as signed zero
		issue(32'h0000_0001, 32'h3f80_0000, OP_ADD, RM_NEAREST, 32'h3f80_0000, 7'h0);
		issue(32'h807f_ffff, 32'h4040_0000, OP_MUL, RM_NEAREST, 32'h8000_0000, FL_ZERO);
		issue(32'h8000_0005, 32'h0000_0003, OP_SUB, RM_NEAREST, 32'h8000_0000, FL_ZERO);
	endtask

	//////////////////////////////
	// Checking
	//////////////////////////////
	always @(posedge clk)
	begin
		vld_pipe <= {vld_pipe[3:0], in_valid};
		if (vld_pipe[3])  // Result lands on this edge
		begin
			exp_out  <= exp_out_q.pop_front();
			exp_flag <= exp_flag_q.pop_front();
		end
	end

	check_out: assert property (@(posedge clk) vld_pipe[4] |-> out == exp_out)
		else stop_with_failure($sformatf("FAILED out: expected %08h, got %08h",
			$sampled(exp_out), $sampled(out)));

	check_flags: assert property (@(posedge clk) vld_pipe[4] |-> flags == exp_flag)
		else stop_with_failure($sformatf("FAILED flags: expected %02h, got %02h",
			$sampled(exp_flag), $sampled(flags)));

	check_reset: assert property (@(posedge clk) reset_window |-> out == '0 && flags == '0)
		else stop_with_failure($sformatf("FAILED out/flags in reset: out %08h, flags %02h",
			$sampled(out), $sampled(flags)));

	//////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////
	initial
	begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		opa          = '0;
		opb          = '0;
		fpu_op       = OP_ADD;
		rmode        = RM_NEAREST;
		in_valid     = 1'b0;
		vld_pipe     = '0;
		reset_window = 1'b1;
		exp_out      = '0;
		exp_flag     = '0;
		seed         = 65;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);
		reset_window <= 1'b0;  // Idle 0+0 reaches the outputs after this
		random_int_ops();
		cancel_ops();
		rounding_ops();
		overflow_ops();
		underflow_ops();
		special_ops();
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_out_q.size() != 0 || vld_pipe != '0)
			@(posedge clk);
		@(posedge clk);  // Last check samples here
		$display("TEST OK");
		$finish;
	end

	initial
	begin
		#((N_OPS + 20) * 20);
		stop_with_failure("Timeout: results did not drain before the watchdog limit");
	end

endmodule

/* files.f */
verilog/fpu_pkg.sv
verilog/operand_classify.sv
verilog/addsub_prenorm.sv
verilog/mul_prenorm.sv
verilog/mantissa_arith.sv
verilog/post_norm.sv
verilog/result_select.sv
verilog/fpu_top.sv
dv/fpu_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = fpu_tb
FILELIST   = files.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
